/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_exu
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "no result line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+verilog
verilog/exu_isa_pkg.sv
verilog/exu_pipe_pkg.sv
verilog/insn_decode.sv
verilog/reg_file.sv
verilog/scoreboard.sv
verilog/pipe_stage.sv
verilog/exec_alu.sv
verilog/exu_top.sv
sim/exu_checker.sv
sim/tb_exu.sv

/* sim/exu_checker.sv */
// result checker for the integer slice
// mirrors the architectural registers and flags, predicts every result
// in issue order and compares it with the result port
`include "exu_settings.svh"

module exu_checker (
  input  logic                   clk,
  input  logic                   rst,
  input  int                     phase,
  input  logic                   issue_valid,
  input  logic                   issue_ready,
  input  logic [`EXU_INSN_W-1:0] issue_insn,
  input  logic                   result_valid,
  input  logic                   result_ready,
  input  logic [`EXU_RA_W-1:0]   result_rd,
  input  logic [`EXU_XLEN-1:0]   result_value,
  input  exu_isa_pkg::flags_t    result_flags,
  input  logic                   result_executed,
  output int                     value_errs,
  output int                     proto_errs,
  output int                     checked,
  output int                     outstanding
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [`EXU_XLEN-1:0]   arch_regs [`EXU_NREGS];
  exu_isa_pkg::flags_t    arch_flags;
  logic [`EXU_INSN_W-1:0] insn_q [$];
  int                     phase_q [$];
  logic                   in_reset;

  function automatic string phase_name(input int p);
    case (p)
      0:       return "reset_smoke";
      1:       return "random_alu";
      2:       return "cond_table";
      3:       return "dep_chain";
      4:       return "backpressure";
      default: return "illegal_op";
    endcase
  endfunction

  // pairs share a base test, odd codes invert it
  function automatic logic cond_holds(input logic [3:0] cnd, input exu_isa_pkg::flags_t f);
    logic base;
    case (cnd[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = f.n ~^ f.v;
      3'd6:    base = ~f.z & (f.n ~^ f.v);
      default: base = 1'b1; // AL, NV
    endcase
    return base ^ cnd[0];
  endfunction

  function automatic void predict(input logic [`EXU_INSN_W-1:0] insn,
                                  output logic [`EXU_RA_W-1:0] e_rd,
                                  output logic [`EXU_XLEN-1:0] e_value,
                                  output exu_isa_pkg::flags_t e_flags,
                                  output logic e_exec);
    logic [3:0]           opc;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic [`EXU_XLEN-1:0] r;
    logic [`EXU_XLEN:0]   wide;
    logic                 c;
    logic                 v;
    opc = insn[31:28];
    e_rd = insn[23:20];
    a = arch_regs[insn[19:16]];
    if (opc < 4'd8) b = arch_regs[insn[3:0]];
    else b = {{(`EXU_XLEN - `EXU_IMM_W){insn[15]}}, insn[15:0]};
    e_value = '0;
    e_flags = arch_flags;
    e_exec = 1'b0;
    if (!cond_holds(insn[27:24], arch_flags) || opc > 4'd12) return;
    e_exec = 1'b1;
    c = 1'b0;
    v = 1'b0;
    case (opc)
      4'd0, 4'd8: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[`EXU_XLEN-1:0];
        c = wide[`EXU_XLEN];
        v = (a[63] == b[63]) && (r[63] != a[63]);
      end
      4'd1: begin
        r = a - b;
        c = a >= b;
        v = (a[63] != b[63]) && (r[63] != a[63]);
      end
      4'd2:       r = a & b;
      4'd3:       r = a ^ b;
      4'd4:       r = a | b;
      4'd5, 4'd9: r = a << b[5:0];
      4'd6, 4'd10: r = a >> b[5:0];
      4'd7, 4'd11: r = $signed(a) >>> b[5:0];
      default:    r = b; // MOVI
    endcase
    e_value = r;
    e_flags.c = c;
    e_flags.v = v;
    e_flags.n = r[63];
    e_flags.z = r == '0;
  endfunction

  task automatic compare(input string test, input string field,
                         input logic [`EXU_XLEN-1:0] exp, input logic [`EXU_XLEN-1:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("ERR %s %s: expected 0x%0h, actual 0x%0h", test, field, exp, act);
    end
  endtask

  always @(posedge clk) begin
    logic [`EXU_INSN_W-1:0] insn;
    logic [`EXU_RA_W-1:0]   e_rd;
    logic [`EXU_XLEN-1:0]   e_value;
    exu_isa_pkg::flags_t    e_flags;
    logic                   e_exec;
    string                  name;
    if (rst) begin
      insn_q.delete();
      phase_q.delete();
      for (int i = 0; i < `EXU_NREGS; i++) arch_regs[i] = '0;
      arch_flags = '0;
      value_errs = 0;
      proto_errs = 0;
      checked = 0;
      in_reset = 1'b1;
    end else begin
      if (in_reset && (result_valid || !issue_ready)) begin
        proto_errs++;
        $display("first cycle after reset: result port busy or issue not ready");
      end
      in_reset = 1'b0;
      if (result_valid && insn_q.size() == 0) begin
        proto_errs++;
        $display("result valid while no instruction is outstanding");
      end else if (result_valid && result_ready) begin
        insn = insn_q.pop_front();
        name = phase_name(phase_q.pop_front());
        predict(insn, e_rd, e_value, e_flags, e_exec);
        compare(name, "rd", 64'(e_rd), 64'(result_rd));
        compare(name, "executed", 64'(e_exec), 64'(result_executed));
        compare(name, "value", e_value, result_value);
        // a suppressed AL op carries the flags it saw at issue
        if (e_exec || insn[27:24] != 4'd14)
          compare(name, "flags", 64'(e_flags), 64'(result_flags));
        if (e_exec) begin
          arch_regs[e_rd] = e_value;
          arch_flags = e_flags;
        end
        checked++;
      end
      if (issue_valid && issue_ready) begin
        insn_q.push_back(issue_insn);
        phase_q.push_back(phase);
      end
    end
    outstanding = insn_q.size();
  end

endmodule

/* sim/tb_exu.sv */
// testbench for the integer execution slice
// issues instruction streams and stalls the result port at random;
// exu_checker predicts and compares every result
`include "exu_settings.svh"

module tb_exu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ISSUE_LIMIT = 200;
  localparam int DRAIN_LIMIT = 1000;
  // 5-5, 7-3, 3-7, min-1, 1-min
  localparam logic [15:0] A_IMM [5] = '{16'd5, 16'd7, 16'd3, 16'd1, 16'd1};
  localparam logic [15:0] A_SH  [5] = '{16'd0, 16'd0, 16'd0, 16'd63, 16'd0};
  localparam logic [15:0] B_IMM [5] = '{16'd5, 16'd3, 16'd7, 16'd1, 16'd1};
  localparam logic [15:0] B_SH  [5] = '{16'd0, 16'd0, 16'd0, 16'd0, 16'd63};

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   issue_valid;
  logic [`EXU_INSN_W-1:0] issue_insn;
  logic                   issue_ready;
  logic                   result_ready;
  logic                   result_valid;
  logic [`EXU_RA_W-1:0]   result_rd;
  logic [`EXU_XLEN-1:0]   result_value;
  exu_isa_pkg::flags_t    result_flags;
  logic                   result_executed;
  integer                 seed;
  integer                 bp_seed;
  int                     phase;
  int                     issued;
  logic                   bp_on;
  logic                   timed_out;
  int                     value_errs;
  int                     proto_errs;
  int                     checked;
  int                     outstanding;

  always #5 clk = ~clk;

  always @(negedge clk) begin
    if (bp_on) result_ready = ($random(bp_seed) & 7) < 5; // stalls about 3 in 8
    else result_ready = 1'b1;
  end

  exu_top u_exu_top (.clk(clk), .rst(rst), .issue_valid(issue_valid), .issue_insn(issue_insn),
    .result_ready(result_ready), .issue_ready(issue_ready), .result_valid(result_valid),
    .result_rd(result_rd), .result_value(result_value), .result_flags(result_flags),
    .result_executed(result_executed));

  exu_checker u_checker (.clk(clk), .rst(rst), .phase(phase), .issue_valid(issue_valid),
    .issue_ready(issue_ready), .issue_insn(issue_insn), .result_valid(result_valid),
    .result_ready(result_ready), .result_rd(result_rd), .result_value(result_value),
    .result_flags(result_flags), .result_executed(result_executed),
    .value_errs(value_errs), .proto_errs(proto_errs), .checked(checked),
    .outstanding(outstanding));

  function automatic logic [31:0] encode(input logic [3:0] opc, input logic [3:0] cnd,
                                         input logic [3:0] rd, input logic [3:0] ra,
                                         input logic [15:0] low);
    return {opc, cnd, rd, ra, low};
  endfunction

  function automatic logic [31:0] random_insn(input logic any_cond);
    logic [31:0] r;
    logic [3:0]  cnd;
    r = $random(seed);
    cnd = any_cond ? r[27:24] : exu_isa_pkg::COND_AL;
    return {4'(r[31:28] % 13), cnd, r[23:0]}; // legal opcodes only
  endfunction

  task automatic send_insn(input logic [31:0] insn);
    int   waited;
    logic accepted;
    if (timed_out) return;
    @(negedge clk);
    issue_valid = 1'b1;
    issue_insn = insn;
    waited = 0;
    accepted = 1'b0;
    while (!accepted && waited < ISSUE_LIMIT) begin
      @(posedge clk);
      accepted = issue_ready;
      waited++;
    end
    if (accepted) issued++;
    else begin
      $display("timeout: issue of %h not accepted within %0d cycles", insn, ISSUE_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      issue_valid = 1'b0;
    end
  endtask

  task automatic drain_results();
    int waited;
    if (timed_out) return;
    idle_cycles(1);
    waited = 0;
    while (outstanding != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (outstanding != 0) begin
      $display("timeout: %0d results still outstanding after %0d cycles", outstanding,
               DRAIN_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  // flags from a SUB, then a predicated MOVI and ADD under each condition
  task automatic run_cond_table();
    for (int p = 0; p < 5; p++) begin
      for (int c = 0; c < 16; c++) begin
        send_insn(encode(exu_isa_pkg::OP_MOVI, exu_isa_pkg::COND_AL, 4'd1, 4'd0, A_IMM[p]));
        send_insn(encode(exu_isa_pkg::OP_SHLI, exu_isa_pkg::COND_AL, 4'd1, 4'd1, A_SH[p]));
        send_insn(encode(exu_isa_pkg::OP_MOVI, exu_isa_pkg::COND_AL, 4'd2, 4'd0, B_IMM[p]));
        send_insn(encode(exu_isa_pkg::OP_SHLI, exu_isa_pkg::COND_AL, 4'd2, 4'd2, B_SH[p]));
        send_insn(encode(exu_isa_pkg::OP_SUB, exu_isa_pkg::COND_AL, 4'd3, 4'd1, 16'd2));
        send_insn(encode(exu_isa_pkg::OP_MOVI, 4'(c), 4'd4, 4'd0, 16'(c + 16)));
        send_insn(encode(exu_isa_pkg::OP_ADD, 4'(c), 4'd5, 4'd4, 16'd3));
      end
    end
  endtask

  task automatic run_dep_chain();
    send_insn(encode(exu_isa_pkg::OP_MOVI, exu_isa_pkg::COND_AL, 4'd5, 4'd0, 16'd1));
    send_insn(encode(exu_isa_pkg::OP_MOVI, exu_isa_pkg::COND_AL, 4'd6, 4'd0, 16'd0));
    repeat (30) begin
      send_insn(encode(exu_isa_pkg::OP_ADDI, exu_isa_pkg::COND_AL, 4'd5, 4'd5,
                       16'($random(seed))));
      send_insn(encode(exu_isa_pkg::OP_ADD, exu_isa_pkg::COND_AL, 4'd6, 4'd6, 16'd5));
      send_insn(encode(exu_isa_pkg::OP_XOR, exu_isa_pkg::COND_AL, 4'd5, 4'd5, 16'd6));
    end
  endtask

  task automatic run_illegal_mix();
    logic [31:0] r;
    repeat (8) begin
      for (int k = 13; k < 16; k++) begin
        r = $random(seed);
        send_insn({4'(k), r[27:0]});
        send_insn(random_insn(1'b1));
      end
    end
  endtask

  initial begin
    seed = 32'h7db1_22cf;
    bp_seed = seed ^ 32'h0f0f_0f0f;
    rst = 1'b1;
    issue_valid = 1'b0;
    issue_insn = '0;
    result_ready = 1'b1;
    bp_on = 1'b0;
    timed_out = 1'b0;
    phase = 0;
    issued = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle_cycles(4);
    send_insn(encode(exu_isa_pkg::OP_MOVI, exu_isa_pkg::COND_AL, 4'd1, 4'd0, 16'h1234));
    send_insn(encode(exu_isa_pkg::OP_ADD, exu_isa_pkg::COND_AL, 4'd2, 4'd3, 16'd4));
    send_insn(encode(exu_isa_pkg::OP_ADD, exu_isa_pkg::COND_AL, 4'd7, 4'd1, 16'd2));
    drain_results();
    phase = 1;
    repeat (150) send_insn(random_insn(1'b0));
    drain_results();
    phase = 2;
    run_cond_table();
    drain_results();
    phase = 3;
    run_dep_chain();
    drain_results();
    phase = 4;
    bp_on = 1'b1;
    repeat (200) begin
      send_insn(random_insn(1'b1));
      idle_cycles($random(seed) & 3);
    end
    drain_results();
    phase = 5;
    run_illegal_mix();
    drain_results();
    if (checked != issued)
      $display("results checked (%0d) do not match instructions issued (%0d)", checked, issued);
    $display("errors: %0d value, %0d protocol, %0d results checked", value_errs, proto_errs,
             checked);
    if (!timed_out && value_errs == 0 && proto_errs == 0 && checked == issued) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/exec_alu.sv */
// predicated integer ALU
// checks the condition against the flags carried from issue, then
// computes the result and the new c, v, n, z flags
`include "exu_settings.svh"

module exec_alu (
  input  exu_pipe_pkg::dec_op_t op,
  output exu_pipe_pkg::result_t res
);

  localparam int SH_W = $clog2(`EXU_XLEN);
  localparam int MSB  = `EXU_XLEN - 1;

  logic                 cond_ok;
  logic                 legal;
  logic [`EXU_XLEN:0]   sum;
  logic [`EXU_XLEN:0]   diff;
  logic [SH_W-1:0]      shamt;
  logic [`EXU_XLEN-1:0] value;
  logic                 c;
  logic                 v;

  function automatic logic cond_eval(exu_isa_pkg::cond_e cond, exu_isa_pkg::flags_t f);
    case (cond)
      exu_isa_pkg::COND_EQ: return f.z;
      exu_isa_pkg::COND_NE: return !f.z;
      exu_isa_pkg::COND_CS: return f.c;
      exu_isa_pkg::COND_CC: return !f.c;
      exu_isa_pkg::COND_MI: return f.n;
      exu_isa_pkg::COND_PL: return !f.n;
      exu_isa_pkg::COND_VS: return f.v;
      exu_isa_pkg::COND_VC: return !f.v;
      exu_isa_pkg::COND_HI: return f.c && !f.z;
      exu_isa_pkg::COND_LS: return !(f.c && !f.z);
      exu_isa_pkg::COND_GE: return f.n == f.v;
      exu_isa_pkg::COND_LT: return f.n != f.v;
      exu_isa_pkg::COND_GT: return !f.z && (f.n == f.v);
      exu_isa_pkg::COND_LE: return !(!f.z && (f.n == f.v));
      exu_isa_pkg::COND_AL: return 1'b1;
      default:              return 1'b0; // NV
    endcase
  endfunction

  assign cond_ok = cond_eval(op.cond, op.flags);
  assign legal   = op.opcode <= exu_isa_pkg::OP_MOVI;
  assign sum     = {1'b0, op.a} + {1'b0, op.b};
  assign diff    = {1'b0, op.a} - {1'b0, op.b};
  assign shamt   = op.b[SH_W-1:0];

  always_comb begin
    value = '0;
    c = 1'b0;
    v = 1'b0;
    case (op.opcode)
      exu_isa_pkg::OP_ADD, exu_isa_pkg::OP_ADDI: begin
        value = sum[MSB:0];
        c = sum[`EXU_XLEN];
        v = (op.a[MSB] == op.b[MSB]) && (sum[MSB] != op.a[MSB]);
      end
      exu_isa_pkg::OP_SUB: begin
        value = diff[MSB:0];
        c = !diff[`EXU_XLEN]; // no borrow
        v = (op.a[MSB] != op.b[MSB]) && (diff[MSB] != op.a[MSB]);
      end
      exu_isa_pkg::OP_AND:                       value = op.a & op.b;
      exu_isa_pkg::OP_XOR:                       value = op.a ^ op.b;
      exu_isa_pkg::OP_OR:                        value = op.a | op.b;
      exu_isa_pkg::OP_SHL, exu_isa_pkg::OP_SHLI: value = op.a << shamt;
      exu_isa_pkg::OP_SHR, exu_isa_pkg::OP_SHRI: value = op.a >> shamt;
      exu_isa_pkg::OP_SAR, exu_isa_pkg::OP_SARI: value = $signed(op.a) >>> shamt;
      exu_isa_pkg::OP_MOVI:                      value = op.b;
      default:                                   value = '0;
    endcase
  end

  always_comb begin
    res.rd     = op.rd;
    res.writes = op.writes;
    if (cond_ok && legal) begin
      res.executed = 1'b1;
      res.value    = value;
      res.flags.c  = c;
      res.flags.v  = v;
      res.flags.n  = value[MSB];
      res.flags.z  = value == '0;
    end else begin
      res.executed = 1'b0; // suppressed, flags pass through
      res.value    = '0;
      res.flags    = op.flags;
    end
  end

endmodule

/* verilog/exu_isa_pkg.sv */
// instruction set of the integer slice
// opcodes, condition codes, flag layout and instruction field positions
package exu_isa_pkg;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_XOR   = 4'd3,
    OP_OR    = 4'd4,
    OP_SHL   = 4'd5,
    OP_SHR   = 4'd6,
    OP_SAR   = 4'd7,
    OP_ADDI  = 4'd8,
    OP_SHLI  = 4'd9,
    OP_SHRI  = 4'd10,
    OP_SARI  = 4'd11,
    OP_MOVI  = 4'd12,
    OP_ILL_D = 4'd13, // 13..15 reserved
    OP_ILL_E = 4'd14,
    OP_ILL_F = 4'd15
  } opcode_e;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  // field lsb positions in the instruction word
  localparam int OPC_LSB  = 28;
  localparam int COND_LSB = 24;
  localparam int RD_LSB   = 20;
  localparam int RA_LSB   = 16;
  localparam int RB_LSB   = 0;
  localparam int IMM_LSB  = 0;
  localparam int FIELD_W  = 4; // opcode and condition fields

endpackage

/* verilog/exu_pipe_pkg.sv */
// pipeline payloads of the integer slice
// dec_op_t travels issue to execute, result_t execute to writeback
`include "exu_settings.svh"

package exu_pipe_pkg;

  typedef struct packed {
    exu_isa_pkg::opcode_e opcode;
    exu_isa_pkg::cond_e   cond;
    logic [`EXU_RA_W-1:0] rd;
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;     // register value or extended immediate
    exu_isa_pkg::flags_t  flags; // flags sampled at issue
    logic                 writes;
  } dec_op_t;

  typedef struct packed {
    logic [`EXU_RA_W-1:0] rd;
    logic [`EXU_XLEN-1:0] value;
    exu_isa_pkg::flags_t  flags;
    logic                 executed;
    logic                 writes; // issue reserved rd and flags
  } result_t;

endpackage

/* verilog/exu_settings.svh */
// execution unit widths
// shared by the payload package and the RTL modules
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data path
`define EXU_XLEN 64
`define EXU_NREGS 16
// log2 of the register count
`define EXU_RA_W 4
`define EXU_IMM_W 16
`define EXU_INSN_W 32

`endif

/* verilog/exu_top.sv */
// integer execution slice
// decode and operand read at issue, execute stage, result stage;
// results write back on the result port handshake
`include "exu_settings.svh"

module exu_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  input  logic [`EXU_INSN_W-1:0] issue_insn,
  input  logic                   result_ready,
  output logic                   issue_ready,
  output logic                   result_valid,
  output logic [`EXU_RA_W-1:0]   result_rd,
  output logic [`EXU_XLEN-1:0]   result_value,
  output exu_isa_pkg::flags_t    result_flags,
  output logic                   result_executed
);

  exu_isa_pkg::opcode_e  dec_opcode;
  exu_isa_pkg::cond_e    dec_cond;
  logic [`EXU_RA_W-1:0]  dec_rd;
  logic [`EXU_RA_W-1:0]  dec_ra;
  logic [`EXU_RA_W-1:0]  dec_rb;
  logic [`EXU_XLEN-1:0]  dec_imm;
  logic                  dec_uses_rb;
  logic                  dec_writes;
  logic [`EXU_XLEN-1:0]  rdata_a;
  logic [`EXU_XLEN-1:0]  rdata_b;
  exu_isa_pkg::flags_t   cur_flags;
  logic                  issue_fire;
  logic                  op_in_ready;
  logic                  op_valid;
  logic                  res_in_ready;
  logic                  res_fire;
  exu_pipe_pkg::dec_op_t op_in;
  exu_pipe_pkg::dec_op_t op_q;
  exu_pipe_pkg::result_t res_d;
  exu_pipe_pkg::result_t res_q;

  assign op_in = '{opcode: dec_opcode, cond: dec_cond, rd: dec_rd, a: rdata_a,
                   b: dec_uses_rb ? rdata_b : dec_imm, flags: cur_flags,
                   writes: dec_writes};

  assign res_fire        = result_valid && result_ready;
  assign result_rd       = res_q.rd;
  assign result_value    = res_q.value;
  assign result_flags    = res_q.flags;
  assign result_executed = res_q.executed;

  insn_decode u_decode (.insn(issue_insn), .opcode(dec_opcode), .cond(dec_cond),
    .rd(dec_rd), .ra(dec_ra), .rb(dec_rb), .imm_ext(dec_imm),
    .uses_rb(dec_uses_rb), .writes(dec_writes));

  reg_file u_reg_file (.clk(clk), .rst(rst), .ra(dec_ra), .rb(dec_rb),
    .we(res_fire && res_q.executed), .wa(res_q.rd), .wd(res_q.value),
    .flags_we(res_fire && res_q.executed), .flags_wd(res_q.flags),
    .rdata_a(rdata_a), .rdata_b(rdata_b), .flags(cur_flags));

  scoreboard u_scoreboard (.clk(clk), .rst(rst), .ra(dec_ra), .rb(dec_rb), .rd(dec_rd),
    .uses_rb(dec_uses_rb), .needs_flags(dec_cond != exu_isa_pkg::COND_AL),
    .writes(dec_writes), .issue_valid(issue_valid), .stage_ready(op_in_ready),
    .clear_en(res_fire), .clear_rd(res_q.rd), .clear_writes(res_q.writes),
    .issue_ready(issue_ready), .issue_fire(issue_fire));

  pipe_stage #(.payload_t(exu_pipe_pkg::dec_op_t)) u_stage_op (.clk(clk), .rst(rst),
    .in_valid(issue_fire), .in_data(op_in), .out_ready(res_in_ready),
    .in_ready(op_in_ready), .out_valid(op_valid), .out_data(op_q));

  exec_alu u_alu (.op(op_q), .res(res_d));

  pipe_stage #(.payload_t(exu_pipe_pkg::result_t)) u_stage_res (.clk(clk), .rst(rst),
    .in_valid(op_valid), .in_data(res_d), .out_ready(result_ready),
    .in_ready(res_in_ready), .out_valid(result_valid), .out_data(res_q));

endmodule

/* verilog/insn_decode.sv */
// instruction decoder
// slices the fixed fields, sign-extends the immediate and
// tells the scoreboard which sources are read and whether a write is reserved
`include "exu_settings.svh"

module insn_decode (
  input  logic [`EXU_INSN_W-1:0] insn,
  output exu_isa_pkg::opcode_e   opcode,
  output exu_isa_pkg::cond_e     cond,
  output logic [`EXU_RA_W-1:0]   rd,
  output logic [`EXU_RA_W-1:0]   ra,
  output logic [`EXU_RA_W-1:0]   rb,
  output logic [`EXU_XLEN-1:0]   imm_ext,
  output logic                   uses_rb,
  output logic                   writes
);

  logic [`EXU_IMM_W-1:0] imm;

  assign opcode = exu_isa_pkg::opcode_e'(
    insn[exu_isa_pkg::OPC_LSB +: exu_isa_pkg::FIELD_W]);
  assign cond = exu_isa_pkg::cond_e'(
    insn[exu_isa_pkg::COND_LSB +: exu_isa_pkg::FIELD_W]);

  assign rd  = insn[exu_isa_pkg::RD_LSB +: `EXU_RA_W];
  assign ra  = insn[exu_isa_pkg::RA_LSB +: `EXU_RA_W];
  assign rb  = insn[exu_isa_pkg::RB_LSB +: `EXU_RA_W];
  assign imm = insn[exu_isa_pkg::IMM_LSB +: `EXU_IMM_W];

  assign imm_ext = {{(`EXU_XLEN - `EXU_IMM_W){imm[`EXU_IMM_W-1]}}, imm};

  // register forms occupy the low opcodes
  assign uses_rb = opcode <= exu_isa_pkg::OP_SAR;

  // never-executing ops reserve nothing
  assign writes = (opcode <= exu_isa_pkg::OP_MOVI) && (cond != exu_isa_pkg::COND_NV);

endmodule

/* verilog/pipe_stage.sv */
// one-entry valid/ready pipeline register
// accepts when empty or when the held item leaves in the same cycle
module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     out_ready,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  assign in_ready = !valid_q || out_ready;

  always_ff @(posedge clk) begin
    if (rst) valid_q <= 1'b0;
    else if (in_ready) valid_q <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) data_q <= in_data;
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // stalled item must not change under the consumer
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* verilog/reg_file.sv */
// architectural register file
// sixteen general registers and the flag register
// two combinational read ports, one write port for each
`include "exu_settings.svh"

module reg_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`EXU_RA_W-1:0] ra,
  input  logic [`EXU_RA_W-1:0] rb,
  input  logic                 we,
  input  logic [`EXU_RA_W-1:0] wa,
  input  logic [`EXU_XLEN-1:0] wd,
  input  logic                 flags_we,
  input  exu_isa_pkg::flags_t  flags_wd,
  output logic [`EXU_XLEN-1:0] rdata_a,
  output logic [`EXU_XLEN-1:0] rdata_b,
  output exu_isa_pkg::flags_t  flags
);

  logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];
  exu_isa_pkg::flags_t  flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
      flags_q <= '0;
    end else begin
      if (we) regs[wa] <= wd; // r0 is an ordinary register
      if (flags_we) flags_q <= flags_wd;
    end
  end

  assign rdata_a = regs[ra];
  assign rdata_b = regs[rb];
  assign flags   = flags_q;

endmodule

/* verilog/scoreboard.sv */
// issue scoreboard
// counts outstanding writes per register and for the flags,
// holds issue while a needed source still has a write in flight
`include "exu_settings.svh"

module scoreboard (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`EXU_RA_W-1:0] ra,
  input  logic [`EXU_RA_W-1:0] rb,
  input  logic [`EXU_RA_W-1:0] rd,
  input  logic                 uses_rb,
  input  logic                 needs_flags,
  input  logic                 writes,
  input  logic                 issue_valid,
  input  logic                 stage_ready,
  input  logic                 clear_en,
  input  logic [`EXU_RA_W-1:0] clear_rd,
  input  logic                 clear_writes,
  output logic                 issue_ready,
  output logic                 issue_fire
);

  localparam int CNT_W = 2; // at most two items in flight

  logic [CNT_W-1:0] reg_cnt [`EXU_NREGS];
  logic [CNT_W-1:0] flag_cnt;
  logic             ra_busy;
  logic             rb_busy;
  logic             fl_busy;
  logic             set_en;
  logic             clr_en;

  assign ra_busy = reg_cnt[ra] != '0;
  assign rb_busy = uses_rb && (reg_cnt[rb] != '0);
  assign fl_busy = needs_flags && (flag_cnt != '0);

  assign issue_ready = stage_ready && !(ra_busy || rb_busy || fl_busy);
  assign issue_fire  = issue_valid && issue_ready;

  assign set_en = issue_fire && writes;
  assign clr_en = clear_en && clear_writes;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        reg_cnt[i] <= '0;
      end
      flag_cnt <= '0;
    end else begin
      for (int i = 0; i < `EXU_NREGS; i++) begin
        reg_cnt[i] <= reg_cnt[i] + CNT_W'(set_en && (rd == i))
                                 - CNT_W'(clr_en && (clear_rd == i));
      end
      flag_cnt <= flag_cnt + CNT_W'(set_en) - CNT_W'(clr_en); // set and clear may coincide
    end
  end

  // a retiring result must match a reservation made at its issue
  a_clear_pending: assert property (@(posedge clk) disable iff (rst)
    clr_en |-> (reg_cnt[clear_rd] != '0) && (flag_cnt != '0));

  // a fresh reservation keeps later readers of rd and the flags waiting
  a_set_pending: assert property (@(posedge clk) disable iff (rst)
    set_en |=> (reg_cnt[$past(rd)] != '0) && (flag_cnt != '0));

endmodule
